// File: Makefile
SIM      := verilator
TOP      := tb_fetch_unit
FILELIST := fetch_unit.f
FLAGS    := --binary --timing --assert -Wno-fatal
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST))) fetch_config.svh

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Passes only when the pass line appears in the simulation output
run: $(BIN)
	./$(BIN) | awk '{ print } /^sim passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// File: fetch_config.svh
/*
 * Fetch front end configuration
 * Sizes of the fetch FIFO and request queue, and the denied execute regions
 */

`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// Number of entries in the fetch FIFO
// New requests issue only while depth minus outstanding leaves room for them
`define FETCH_FIFO_DEPTH 3

// Maximum number of requests in flight on the instruction memory port
// The outstanding queue in the prefetch buffer is built for exactly two
`define FETCH_NUM_REQS 2

// Denied execute regions, as word aligned byte addresses
// The base is inclusive and the limit is exclusive
// A region whose limit is not above its base is disabled

// Region 0 covers eight words
`define PMP_R0_BASE  32'h0000_0100
`define PMP_R0_LIMIT 32'h0000_0120

// Region 1 covers eight words a little further up
`define PMP_R1_BASE  32'h0000_0180
`define PMP_R1_LIMIT 32'h0000_01a0

`endif

// File: fetch_fifo.sv
/*
 * Fetch FIFO
 * Holds returned words with their address and error until the core takes them
 * A word arriving while the FIFO is empty falls straight through to the output
 */

`include "fetch_config.svh"

module fetch_fifo
  import fetch_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,

  // Flush on a branch
  input  logic         clear_i,

  // Push side from the prefetch buffer
  input  logic         in_valid_i,
  input  fetch_entry_t in_entry_i,
  output logic         in_ready_o,

  // Pop side towards the core
  output logic         out_valid_o,
  input  logic         out_ready_i,
  output fetch_entry_t out_entry_o
);

  localparam int unsigned DEPTH    = `FETCH_FIFO_DEPTH;
  localparam int unsigned NUM_REQS = `FETCH_NUM_REQS;
  localparam int unsigned CNT_W    = $clog2(DEPTH + 1);

  fetch_entry_t     entries_q [DEPTH];
  fetch_entry_t     entries_d [DEPTH];
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_d;
  logic [CNT_W-1:0] wr_idx;
  logic             empty;
  logic             push_store;
  logic             pop_store;

  //////////////////////////////////////////////////
  // Output side
  //////////////////////////////////////////////////

  assign empty = (count_q == '0);

  // When empty the incoming word is presented directly
  assign out_entry_o = empty ? in_entry_i : entries_q[0];

  // Nothing is offered in a flush cycle since every word in it is stale
  assign out_valid_o = ~clear_i & (in_valid_i | ~empty);

  // Room for every request that could still be outstanding after a new issue
  // Requests already in flight are always accepted on the push side
  assign in_ready_o = (count_q <= CNT_W'(DEPTH - NUM_REQS));

  //////////////////////////////////////////////////
  // Storage update
  //////////////////////////////////////////////////

  // A stored word leaves when the core takes it
  assign pop_store = out_ready_i & ~empty;

  // A bypassed word taken in the same cycle never needs a slot
  assign push_store = in_valid_i & ~(empty & out_ready_i);

  // The new word lands just behind the last word that remains
  assign wr_idx = count_q - CNT_W'(pop_store);

  always_comb begin
    entries_d = entries_q;
    // Shift towards the head on a pop
    if (pop_store) begin
      for (int i = 0; i < DEPTH - 1; i++) begin
        entries_d[i] = entries_q[i + 1];
      end
    end
    if (push_store) begin
      entries_d[wr_idx] = in_entry_i;
    end
  end

  // Fill count moves by one in each direction and a flush empties it
  always_comb begin
    count_d = count_q + CNT_W'(push_store) - CNT_W'(pop_store);
    if (clear_i) begin
      count_d = '0;
    end
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else begin
      count_q <= count_d;
    end
  end

  always_ff @(posedge clk_i) begin
    entries_q <= entries_d;
  end

endmodule

// File: fetch_pkg.sv
/*
 * Fetch front end types
 * Packed structs for the core command, fetched entries and the memory port
 */

package fetch_pkg;

  // Command from the core
  // A set branch bit loads addr as the new fetch target
  typedef struct packed {
    logic        branch;
    logic [31:0] addr;
  } fetch_req_t;

  // One fetched word with the address it came from
  // err marks a bus error or a denied execute region
  typedef struct packed {
    logic [31:0] rdata;
    logic [31:0] addr;
    logic        err;
  } fetch_entry_t;

  // Address phase towards instruction memory
  typedef struct packed {
    logic        req;
    logic [31:0] addr;
  } imem_req_t;

  // Grant and data phase from instruction memory
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } imem_rsp_t;

endpackage

// File: fetch_pmp.sv
/*
 * Execute permission checker
 * Flags fetch addresses that fall inside one of two denied regions
 */

`include "fetch_config.svh"

module fetch_pmp (
  input  logic [31:0] addr_i,
  output logic        deny_o
);

  localparam logic [31:0] R0_BASE  = `PMP_R0_BASE;
  localparam logic [31:0] R0_LIMIT = `PMP_R0_LIMIT;
  localparam logic [31:0] R1_BASE  = `PMP_R1_BASE;
  localparam logic [31:0] R1_LIMIT = `PMP_R1_LIMIT;

  logic [31:0] addr_w;
  logic        r0_hit;
  logic        r1_hit;

  // A region only matches when it is enabled, that is when limit lies above base
  function automatic logic region_hit(input logic [31:0] base,
                                      input logic [31:0] limit,
                                      input logic [31:0] addr);
    logic enabled;
    enabled = limit > base;
    return enabled & (addr >= base) & (addr < limit);
  endfunction

  // Fetches are whole words so the byte offset plays no part
  assign addr_w = {addr_i[31:2], 2'b00};

  assign r0_hit = region_hit(R0_BASE, R0_LIMIT, addr_w);
  assign r1_hit = region_hit(R1_BASE, R1_LIMIT, addr_w);

  // Either region is enough to deny the fetch
  assign deny_o = r0_hit | r1_hit;

endmodule

// File: fetch_unit.f
+incdir+.
fetch_pkg.sv
fetch_pmp.sv
fetch_fifo.sv
prefetch_buffer.sv
fetch_unit.sv
tb_fetch_unit_asserts.sv
tb_fetch_unit.sv

// File: fetch_unit.sv
/*
 * Instruction fetch front end
 * Joins the prefetch buffer and the execute permission checker
 */

module fetch_unit
  import fetch_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,

  // Core side
  input  logic         req_i,
  input  fetch_req_t   cmd_i,
  input  logic         ready_i,
  output logic         valid_o,
  output fetch_entry_t entry_o,

  // Instruction memory side
  output imem_req_t    imem_req_o,
  input  imem_rsp_t    imem_rsp_i,

  output logic         busy_o
);

  // Address under check and its verdict, both in the same cycle
  logic [31:0] pmp_addr;
  logic        pmp_deny;

  prefetch_buffer i_prefetch_buffer (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .cmd_i      (cmd_i),
    .ready_i    (ready_i),
    .valid_o    (valid_o),
    .entry_o    (entry_o),
    .pmp_addr_o (pmp_addr),
    .pmp_deny_i (pmp_deny),
    .imem_req_o (imem_req_o),
    .imem_rsp_i (imem_rsp_i),
    .busy_o     (busy_o)
  );

  // Checker sits beside the buffer on the request address path
  fetch_pmp i_fetch_pmp (
    .addr_i (pmp_addr),
    .deny_o (pmp_deny)
  );

endmodule

// File: prefetch_buffer.sv
/*
 * Prefetch buffer
 * Issues sequential word fetches, tracks up to two outstanding requests,
 * drops responses overtaken by a branch and fills the fetch FIFO
 */

`include "fetch_config.svh"

module prefetch_buffer
  import fetch_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,

  // Core side
  input  logic         req_i,
  input  fetch_req_t   cmd_i,
  input  logic         ready_i,
  output logic         valid_o,
  output fetch_entry_t entry_o,

  // Execute permission check of the current request address
  output logic [31:0]  pmp_addr_o,
  input  logic         pmp_deny_i,

  // Instruction memory side
  output imem_req_t    imem_req_o,
  input  imem_rsp_t    imem_rsp_i,

  output logic         busy_o
);

  localparam int unsigned NUM_REQS = `FETCH_NUM_REQS;

  logic                branch;
  logic [31:0]         target_addr;
  logic                new_req;
  logic                valid_req;
  logic                valid_req_q, valid_req_d;
  logic                discard_req_q, discard_req_d;
  logic                pmp_err_q, pmp_err_d;
  logic                bus_gnt, fake_gnt, gnt_or_pmp_err;
  logic                new_entry, new_abort;
  logic                rvalid_or_pmp_err;
  logic [31:0]         req_addr, held_addr_q;
  logic [31:0]         next_addr_q, next_addr_d;
  logic [31:0]         rsp_addr_q, rsp_addr_d;
  logic [NUM_REQS-1:0] out_q, out_n, out_d;
  logic [NUM_REQS-1:0] abort_q, abort_n, abort_d;
  logic [NUM_REQS-1:0] entry_err_q, entry_err_n, entry_err_d;
  logic                fifo_ready, fifo_valid;
  fetch_entry_t        fifo_entry;

  assign branch      = cmd_i.branch;
  assign target_addr = {cmd_i.addr[31:2], 2'b00};

  //////////////////////////////////////////////////
  // Requests
  //////////////////////////////////////////////////

  // Issue when the FIFO has room and the queue has a free slot
  // A branch flushes the FIFO so it does not wait for room there
  assign new_req   = req_i & ~valid_req_q & (fifo_ready | branch) & ~out_q[NUM_REQS-1];
  assign valid_req = valid_req_q | new_req;

  // An ungranted request keeps its address, even past a branch
  assign req_addr = valid_req_q ? held_addr_q :
                    branch      ? target_addr :
                                  next_addr_q;

  // Denied addresses never reach the bus
  assign pmp_addr_o      = req_addr;
  assign imem_req_o.req  = valid_req & ~pmp_deny_i;
  assign imem_req_o.addr = req_addr;

  // A denied request is held one cycle and then granted from the registered error
  assign bus_gnt        = imem_req_o.req & imem_rsp_i.gnt;
  assign fake_gnt       = valid_req_q & pmp_err_q;
  assign gnt_or_pmp_err = bus_gnt | fake_gnt;

  assign valid_req_d = valid_req & ~gnt_or_pmp_err;
  assign pmp_err_d   = valid_req_d & pmp_deny_i;

  // A held request overtaken by a branch still completes but its data is dropped
  assign new_abort     = valid_req_q & (branch | discard_req_q);
  assign discard_req_d = valid_req_d & new_abort;

  // The fetch address moves on as soon as a request goes out
  assign next_addr_d = (branch ? target_addr : next_addr_q) + (new_req ? 32'd4 : 32'd0);

  //////////////////////////////////////////////////
  // Outstanding request queue
  //////////////////////////////////////////////////

  assign new_entry = valid_req & gnt_or_pmp_err;

  // Slot 0 always holds the oldest request and a new one takes the first free slot
  for (genvar i = 0; i < NUM_REQS; i++) begin : g_slot
    logic land;
    if (i == 0) begin : g_first
      assign land = new_entry & ~out_q[0];
    end else begin : g_next
      assign land = new_entry & ~out_q[i] & out_q[i-1];
    end
    assign out_n[i]       = out_q[i] | land;
    // Every request in flight at a branch is marked for discard
    assign abort_n[i]     = (out_q[i] & (abort_q[i] | branch)) | (land & new_abort);
    assign entry_err_n[i] = (out_q[i] & entry_err_q[i]) | (land & fake_gnt);
  end

  // Faked requests complete on their own once they reach the head
  assign rvalid_or_pmp_err = out_q[0] & (imem_rsp_i.rvalid | entry_err_q[0]);

  // Shift towards slot 0 when the oldest request completes
  assign out_d       = rvalid_or_pmp_err ? {1'b0, out_n[NUM_REQS-1:1]} : out_n;
  assign abort_d     = rvalid_or_pmp_err ? {1'b0, abort_n[NUM_REQS-1:1]} : abort_n;
  assign entry_err_d = rvalid_or_pmp_err ? {1'b0, entry_err_n[NUM_REQS-1:1]} : entry_err_n;

  //////////////////////////////////////////////////
  // Response address and FIFO
  //////////////////////////////////////////////////

  // Surviving responses are consecutive words from the last branch target
  assign rsp_addr_d = branch     ? target_addr :
                      fifo_valid ? rsp_addr_q + 32'd4 :
                                   rsp_addr_q;

  assign fifo_valid       = rvalid_or_pmp_err & ~abort_q[0];
  assign fifo_entry.rdata = entry_err_q[0] ? 32'd0 : imem_rsp_i.rdata;
  assign fifo_entry.addr  = rsp_addr_q;
  assign fifo_entry.err   = entry_err_q[0] | imem_rsp_i.err;

  fetch_fifo i_fetch_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (branch),
    .in_valid_i  (fifo_valid),
    .in_entry_i  (fifo_entry),
    .in_ready_o  (fifo_ready),
    .out_valid_o (valid_o),
    .out_ready_i (ready_i),
    .out_entry_o (entry_o)
  );

  assign busy_o = (|out_q) | valid_req;

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_req_q   <= 1'b0;
      discard_req_q <= 1'b0;
      pmp_err_q     <= 1'b0;
      out_q         <= '0;
      abort_q       <= '0;
      entry_err_q   <= '0;
      next_addr_q   <= '0;
      rsp_addr_q    <= '0;
    end else begin
      valid_req_q   <= valid_req_d;
      discard_req_q <= discard_req_d;
      pmp_err_q     <= pmp_err_d;
      out_q         <= out_d;
      abort_q       <= abort_d;
      entry_err_q   <= entry_err_d;
      next_addr_q   <= next_addr_d;
      rsp_addr_q    <= rsp_addr_d;
    end
  end

  // Captured whenever no request is held so it is ready if the grant is late
  always_ff @(posedge clk_i) begin
    if (!valid_req_q) begin
      held_addr_q <= req_addr;
    end
  end

endmodule

// File: tb_fetch_unit.sv
/*
 * Testbench for the instruction fetch front end
 * Random memory timing and core back-pressure, checked against a stream model
 */

`include "fetch_config.svh"

module tb_fetch_unit
  import fetch_pkg::*;
();

  logic         clk_i;
  logic         rst_ni;
  logic         req_i;
  fetch_req_t   cmd_i;
  logic         ready_i;
  logic         valid_o;
  fetch_entry_t entry_o;
  imem_req_t    imem_req_o;
  imem_rsp_t    imem_rsp_i;
  logic         busy_o;

  // Random source and memory responder state
  logic [15:0]  lfsr_q;
  logic [31:0]  mem_addr_q [$];
  int           mem_wait_q [$];
  int           gap_cnt;

  // Stream model and counters
  logic         run_req;
  logic         random_ready;
  logic         idle_check;
  logic         hold_pending;
  logic [31:0]  exp_addr;
  int           errors;
  int           errors_base;
  int           test_consumed;
  int           test_denied;
  int           total_consumed;
  int           tests_run;
  int           waited;

  fetch_unit i_dut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .cmd_i      (cmd_i),
    .ready_i    (ready_i),
    .valid_o    (valid_o),
    .entry_o    (entry_o),
    .imem_req_o (imem_req_o),
    .imem_rsp_i (imem_rsp_i),
    .busy_o     (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Fibonacci LFSR with taps 16 14 13 11, stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  // Memory contents are the word address scrambled by a constant
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return {2'b00, addr[31:2]} ^ 32'h5a3c_96e1;
  endfunction

  // Inclusive base, exclusive limit, and an empty range never matches
  function automatic logic in_denied(input logic [31:0] addr);
    logic [31:0] a;
    a = {addr[31:2], 2'b00};
    return ((`PMP_R0_LIMIT > `PMP_R0_BASE) && a >= `PMP_R0_BASE && a < `PMP_R0_LIMIT) ||
           ((`PMP_R1_LIMIT > `PMP_R1_BASE) && a >= `PMP_R1_BASE && a < `PMP_R1_LIMIT);
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // Falling edge: memory responses, grant level and core inputs
  task automatic drive();
    foreach (mem_wait_q[i]) begin
      if (mem_wait_q[i] > 0) mem_wait_q[i]--;
    end
    imem_rsp_i.rvalid = 1'b0;
    imem_rsp_i.rdata  = '0;
    // Responses leave strictly in grant order, one per cycle
    if (mem_wait_q.size() > 0 && mem_wait_q[0] == 0) begin
      imem_rsp_i.rvalid = 1'b1;
      imem_rsp_i.rdata  = mem_word(mem_addr_q[0]);
      void'(mem_addr_q.pop_front());
      void'(mem_wait_q.pop_front());
    end
    imem_rsp_i.gnt = (gap_cnt == 0);
    imem_rsp_i.err = 1'b0;
    req_i          = run_req;
    ready_i        = random_ready ? (rand_bits(1) != 0) : 1'b1;
    cmd_i.branch   = 1'b0;
  endtask

  // Just before the rising edge every input and output has settled
  task automatic sample();
    // Anything on the bus or still owed by memory keeps the unit busy
    if ((imem_req_o.req || mem_addr_q.size() > 0) && !busy_o) begin
      $display("busy_o was low while a memory request was pending");
      errors++;
    end
    if (imem_req_o.req && in_denied(imem_req_o.addr)) begin
      $display("denied address %h was requested on the bus", imem_req_o.addr);
      errors++;
    end
    if (imem_req_o.req && imem_rsp_i.gnt) begin
      mem_addr_q.push_back(imem_req_o.addr);
      mem_wait_q.push_back(int'(rand_bits(2)) + 1);
      gap_cnt = int'(rand_bits(2));
    end else if (gap_cnt > 0) begin
      gap_cnt--;
    end
    // An offered entry stays offered until taken or flushed
    if (hold_pending && !cmd_i.branch && !valid_o) begin
      $display("valid_o dropped while entry %h was still waiting", exp_addr);
      errors++;
    end
    if (valid_o && ready_i) begin
      compare("entry_o.addr", entry_o.addr, exp_addr);
      compare("entry_o.rdata", entry_o.rdata, in_denied(exp_addr) ? 32'd0 : mem_word(exp_addr));
      compare("entry_o.err", 32'(entry_o.err), 32'(in_denied(exp_addr)));
      if (entry_o.err) test_denied++;
      exp_addr = exp_addr + 32'd4;
      test_consumed++;
      total_consumed++;
    end
    // After a branch the stream restarts at the aligned target
    if (cmd_i.branch) exp_addr = {cmd_i.addr[31:2], 2'b00};
    hold_pending = valid_o && !ready_i;
    if (idle_check && (imem_req_o.req || busy_o)) begin
      $display("a request or busy_o showed up while the fetch unit should be idle");
      errors++;
    end
  endtask

  task automatic cycle();
    #3;
    sample();
    @(negedge clk_i);
    drive();
  endtask

  task automatic do_branch(input logic [31:0] target);
    req_i        = run_req;
    cmd_i.branch = 1'b1;
    cmd_i.addr   = target;
    cycle();
  endtask

  task automatic run_until(input int count, input int limit);
    int cycles;
    cycles = 0;
    while (test_consumed < count && cycles < limit) begin
      cycle();
      cycles++;
    end
    if (test_consumed < count) begin
      $display("timeout: only %0d of %0d entries arrived", test_consumed, count);
      errors++;
    end
  endtask

  task automatic begin_test();
    errors_base   = errors;
    test_consumed = 0;
    test_denied   = 0;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    $display("test %0d %s done, %0d entries, %0d errors",
             tests_run, name, test_consumed, errors - errors_base);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    lfsr_q         = 16'd56473;
    rst_ni         = 1'b0;
    req_i          = 1'b0;
    cmd_i          = '0;
    ready_i        = 1'b0;
    imem_rsp_i     = '0;
    gap_cnt        = 0;
    run_req        = 1'b0;
    random_ready   = 1'b0;
    idle_check     = 1'b0;
    hold_pending   = 1'b0;
    exp_addr       = '0;
    errors         = 0;
    total_consumed = 0;
    tests_run      = 0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;

    begin_test();
    run_req = 1'b1;
    do_branch(32'h0000_0000);
    run_until(64, 2000);
    end_test("sequential fetch");

    begin_test();
    random_ready = 1'b1;
    do_branch(32'h0000_0402);
    run_until(64, 4000);
    end_test("ready back-pressure");

    // Branches land every few cycles, often with two requests in flight
    begin_test();
    do_branch(32'h0000_0800);
    waited = 0;
    while (test_consumed < 128 && waited < 6000) begin
      if (rand_bits(3) == 0) do_branch(rand_bits(12));
      else cycle();
      waited++;
    end
    if (test_consumed < 128) begin
      $display("timeout: only %0d entries arrived across random branches", test_consumed);
      errors++;
    end
    end_test("random branches");

    // Eight words before region 0, then on through region 1
    begin_test();
    random_ready = 1'b0;
    do_branch(32'h0000_00e0);
    run_until(56, 2000);
    compare("denied entries", 32'(test_denied), 32'd16);
    end_test("denied regions");

    begin_test();
    run_req = 1'b0;
    waited  = 0;
    while ((busy_o || valid_o) && waited < 200) begin
      cycle();
      waited++;
    end
    if (busy_o || valid_o) begin
      $display("timeout: the fetch unit did not go idle with req_i low");
      errors++;
    end
    idle_check = 1'b1;
    repeat (20) cycle();
    idle_check = 1'b0;
    end_test("idle");

    errors += int'(i_dut.i_asserts.failures);
    $display("%0d tests, %0d entries checked, %0d errors", tests_run, total_consumed, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: tb_fetch_unit_asserts.sv
/*
 * Fetch unit port assertions
 * Memory handshake, outstanding limit and reset state, bound to the top level
 */

`include "fetch_config.svh"

module tb_fetch_unit_asserts
  import fetch_pkg::*;
(
  input logic      clk_i,
  input logic      rst_ni,
  input imem_req_t imem_req_i,
  input imem_rsp_t imem_rsp_i,
  input logic      valid_i,
  input logic      busy_i
);

  // Real grants minus returned responses, faked grants never reach the bus
  logic [2:0] outstanding_q;

  // Number of assertion failures seen so far
  int unsigned failures = 0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_q + 3'(imem_req_i.req & imem_rsp_i.gnt)
                       - 3'(imem_rsp_i.rvalid);
    end
  end

  // Address phase holds until granted
  req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    imem_req_i.req && !imem_rsp_i.gnt |=> imem_req_i.req && $stable(imem_req_i.addr))
    else begin
      $error("memory request dropped or changed address before its grant");
      failures++;
    end

  outstanding_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    outstanding_q <= 3'd2)
    else begin
      $error("more than two memory requests outstanding");
      failures++;
    end

  // Nothing is requested or offered while in reset
  reset_a: assert property (@(posedge clk_i)
    !rst_ni |-> !imem_req_i.req && !valid_i && !busy_i)
    else begin
      $error("request, valid or busy high during reset");
      failures++;
    end

  num_reqs_a: assert property (@(posedge clk_i) `FETCH_NUM_REQS == 2)
    else begin
      $error("outstanding request limit is not two");
      failures++;
    end

endmodule

bind fetch_unit tb_fetch_unit_asserts i_asserts (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .imem_req_i (imem_req_o),
  .imem_rsp_i (imem_rsp_i),
  .valid_i    (valid_o),
  .busy_i     (busy_o)
);
